// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module commitUnitTb -o simv
	./obj_dir/simv > sim.log 2>&1 || echo "ERRORS FOUND" >> sim.log
	cat sim.log
	@if grep -q "ERRORS FOUND" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: source/commitConfig.sv
`timescale 1ns/1ps

module commitConfig
	import issuePkg::*, commitPkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  logic     cfgWrite,
	input  cfgRegT   cfgSelect,
	input  laneMaskT cfgWriteData,
	input  countT    occupancy,			// From the ring controller
	output laneMaskT laneEnable,
	output logic     commitHold,
	output laneMaskT cfgReadData
);

	////////////////////////////////////////
	// Steering registers
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			laneEnable <= '1;		// All lanes on
			commitHold <= 1'b0;
		end else if (cfgWrite) begin
			case (cfgSelect)
				regLaneEnable: laneEnable <= cfgWriteData;
				regCommitHold: commitHold <= cfgWriteData[0];
				default: ;		// Occupancy is read only
			endcase
		end
	end

	////////////////////////////////////////
	// Readback
	////////////////////////////////////////

	always_comb begin
		cfgReadData = '0;
		case (cfgSelect)
			regLaneEnable: cfgReadData = laneEnable;
			regCommitHold: cfgReadData[0] = commitHold;
			regOccupancy:  cfgReadData[entryWidth:0] = occupancy;
			default:       cfgReadData = '0;
		endcase
	end

endmodule

// File: source/commitPkg.sv
package commitPkg;

	////////////////////////////////////////
	// Entry state
	////////////////////////////////////////

	// Free until stored, pending while lanes run, done when all lanes report
	typedef enum logic [1:0] {
		entryFree,
		entryPending,
		entryDone
	} entryStateT;

	////////////////////////////////////////
	// Config register select
	////////////////////////////////////////

	typedef enum logic [1:0] {
		regLaneEnable,		// Lane-enable mask, read and write
		regCommitHold,		// Commit hold in bit 0
		regOccupancy		// Entries in flight, read only
	} cfgRegT;

endpackage

// File: source/commitUnit.sv
`timescale 1ns/1ps

module commitUnit
	import issuePkg::*, commitPkg::*;
(
	input  logic                    clock,
	input  logic                    reset,
	// Dispatch side
	input  logic                    storeValid,
	input  issueNoT                 storeIssueNo,
	input  laneMaskT                storeLanes,
	output entryIdxT                allocEntry,
	output logic                    creditReturn,
	// Lanes
	input  laneMaskT                laneDone,
	input  entryIdxT [numLanes-1:0] laneEntry,
	// Commit side
	output logic                    commitValid,
	output issueNoT                 commitIssueNo,
	input  logic                    commitGrant,
	// Config port
	input  logic                    cfgWrite,
	input  cfgRegT                  cfgSelect,
	input  laneMaskT                cfgWriteData,
	output laneMaskT                cfgReadData
);

	laneMaskT laneEnable;
	logic     commitHold;
	countT    occupancy;

	commitConfig cfgBlock (
		.clock        (clock),
		.reset        (reset),
		.cfgWrite     (cfgWrite),
		.cfgSelect    (cfgSelect),
		.cfgWriteData (cfgWriteData),
		.occupancy    (occupancy),
		.laneEnable   (laneEnable),
		.commitHold   (commitHold),
		.cfgReadData  (cfgReadData)
	);

	reorderBuffer rob (
		.clock         (clock),
		.reset         (reset),
		.storeValid    (storeValid),
		.storeIssueNo  (storeIssueNo),
		.storeLanes    (storeLanes),
		.allocEntry    (allocEntry),
		.creditReturn  (creditReturn),
		.laneDone      (laneDone),
		.laneEntry     (laneEntry),
		.commitValid   (commitValid),
		.commitIssueNo (commitIssueNo),
		.commitGrant   (commitGrant),
		.laneEnable    (laneEnable),
		.commitHold    (commitHold),
		.occupancy     (occupancy)		// Also read back through config
	);

endmodule

// File: source/issuePkg.sv
package issuePkg;

	////////////////////////////////////////
	// Buffer and lane sizes
	////////////////////////////////////////

	localparam int numEntries = 16;			// Reorder buffer depth
	localparam int entryWidth = 4;			// Bits of an entry index
	localparam int numLanes   = 8;			// Vector lanes
	localparam int issueWidth = 8;			// Bits of an issue number

	////////////////////////////////////////
	// Issue-side types
	////////////////////////////////////////

	typedef logic [issueWidth-1:0] issueNoT;

	typedef logic [entryWidth-1:0] entryIdxT;

	// One bit per lane
	typedef logic [numLanes-1:0] laneMaskT;

	// Occupancy reaches numEntries, hence one extra bit
	typedef logic [entryWidth:0] countT;

endpackage

// File: source/reorderBuffer.sv
`timescale 1ns/1ps

module reorderBuffer
	import issuePkg::*, commitPkg::*;
(
	input  logic                    clock,
	input  logic                    reset,
	// Dispatch side
	input  logic                    storeValid,
	input  issueNoT                 storeIssueNo,
	input  laneMaskT                storeLanes,
	output entryIdxT                allocEntry,
	output logic                    creditReturn,
	// Lane completion
	input  laneMaskT                laneDone,
	input  entryIdxT [numLanes-1:0] laneEntry,
	// Commit side
	output logic                    commitValid,
	output issueNoT                 commitIssueNo,
	input  logic                    commitGrant,
	// Steering from the config block
	input  laneMaskT                laneEnable,
	input  logic                    commitHold,
	output countT                   occupancy
);

	entryStateT entryState        [numEntries];
	issueNoT    entryIssueNo      [numEntries];
	laneMaskT   entryPendingLanes [numEntries];

	laneMaskT   laneClear   [numEntries];
	laneMaskT   nextPending [numEntries];
	laneMaskT   storeMask;

	logic       doStore;
	logic       doCommit;
	entryIdxT   headIdx;
	entryIdxT   tailIdx;
	logic       full;
	logic       empty;

	////////////////////////////////////////
	// Store and commit handshakes
	////////////////////////////////////////

	assign storeMask  = storeLanes & laneEnable;		// Disabled lanes never report
	assign doStore    = storeValid & ~full;
	assign allocEntry = tailIdx;

	// Head is offered only once every lane of it is done
	assign commitValid   = ~empty & (entryState[headIdx] == entryDone) & ~commitHold;
	assign commitIssueNo = entryIssueNo[headIdx];
	assign doCommit      = commitValid & commitGrant;

	////////////////////////////////////////
	// Lane completion decode
	////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < numEntries; i++) begin
			laneClear[i] = '0;
			for (int l = 0; l < numLanes; l++) begin
				if (laneDone[l] && (laneEntry[l] == entryIdxT'(i)))
					laneClear[i][l] = 1'b1;
			end
			nextPending[i] = entryPendingLanes[i] & ~laneClear[i];
		end
	end

	////////////////////////////////////////
	// Entry state
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < numEntries; i++)
				entryState[i] <= entryFree;
		end else begin
			for (int i = 0; i < numEntries; i++) begin
				if ((entryState[i] == entryPending) && (nextPending[i] == '0))
					entryState[i] <= entryDone;		// Last lane just reported
			end
			if (doCommit)
				entryState[headIdx] <= entryFree;
			// Store wins, the tail is never the head being freed
			if (doStore)
				entryState[tailIdx] <= (storeMask == '0) ? entryDone : entryPending;
		end
	end

	// Payload of each entry
	always_ff @(posedge clock) begin
		for (int i = 0; i < numEntries; i++)
			entryPendingLanes[i] <= nextPending[i];
		if (doStore) begin
			entryIssueNo[tailIdx]      <= storeIssueNo;
			entryPendingLanes[tailIdx] <= storeMask;
		end
	end

	// One credit back per retired entry
	always_ff @(posedge clock) begin
		if (reset)
			creditReturn <= 1'b0;
		else
			creditReturn <= doCommit;
	end

	ringBufferControl ringCtrl (
		.clock     (clock),
		.reset     (reset),
		.doStore   (doStore),
		.doCommit  (doCommit),
		.headIdx   (headIdx),
		.tailIdx   (tailIdx),
		.full      (full),
		.empty     (empty),
		.occupancy (occupancy)
	);

endmodule

// File: source/ringBufferControl.sv
`timescale 1ns/1ps

module ringBufferControl
	import issuePkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  logic     doStore,			// Entry written at tail
	input  logic     doCommit,			// Entry retired at head
	output entryIdxT headIdx,
	output entryIdxT tailIdx,
	output logic     full,
	output logic     empty,
	output countT    occupancy
);

	////////////////////////////////////////
	// Pointers
	////////////////////////////////////////

	// Depth is a power of two, so the pointers wrap by themselves
	always_ff @(posedge clock) begin
		if (reset) begin
			headIdx <= '0;
			tailIdx <= '0;
		end else begin
			if (doStore)
				tailIdx <= tailIdx + 1'b1;
			if (doCommit)
				headIdx <= headIdx + 1'b1;
		end
	end

	////////////////////////////////////////
	// Occupancy
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			occupancy <= '0;
		end else begin
			case ({doStore, doCommit})
				2'b10:   occupancy <= occupancy + 1'b1;
				2'b01:   occupancy <= occupancy - 1'b1;
				default: occupancy <= occupancy;		// Both or neither
			endcase
		end
	end

	assign full  = (occupancy == countT'(numEntries));
	assign empty = (occupancy == '0);

endmodule

// File: testbench/commitStim.txt
# op argA argB in hex. S store issue lanes, F fill count=argB from issue=argA, L finish lanes
# D drain commits, G grant 0 low 1 high 2 random, I idle cycles, K credits expected
# W config write select data, R config read select expected (0 lanes, 1 hold, 2 occupancy)
G 2 0
S 01 ff
S 02 0f
S 03 f0
S 04 81
S 05 3c
L 0 0
D 0 0
K 10 0
W 0 0f
R 0 0f
S 07 f0
S 08 00
S 09 33
L 0 0
D 0 0
W 0 ff
R 0 ff
G 0 0
S 0a 11
S 0b 22
S 0c 44
L 0 0
I 8 0
R 2 03
K 0d 0
G 2 0
D 0 0
G 1 0
W 1 01
R 1 01
S 0d 01
S 0e 80
L 0 0
I 8 0
R 2 02
W 1 00
D 0 0
G 0 0
F 20 10
K 0 0
R 2 10
L 0 0
I 4 0
R 2 10
G 2 0
S 30 ff
L 0 0
D 0 0
K 10 0
R 2 00

// File: testbench/commitUnitTb.sv
`timescale 1ns/1ps

module commitUnitTb
	import issuePkg::*, commitPkg::*;
();

	localparam int clockPeriod   = 10;
	localparam int cyclesPerLine = 40;

	logic                    clock;
	logic                    reset;
	logic                    storeValid;
	issueNoT                 storeIssueNo;
	laneMaskT                storeLanes;
	entryIdxT                allocEntry;
	logic                    creditReturn;
	laneMaskT                laneDone;
	entryIdxT [numLanes-1:0] laneEntry;
	logic                    commitValid;
	issueNoT                 commitIssueNo;
	logic                    commitGrant;
	logic                    cfgWrite;
	cfgRegT                  cfgSelect;
	laneMaskT                cfgWriteData;
	laneMaskT                cfgReadData;

	// Dispatcher and lane model
	issueNoT  expectQ [$];
	laneMaskT pendingModel [numEntries];
	entryIdxT tailModel;
	entryIdxT headModel;
	laneMaskT enableModel;
	logic     holdModel;
	int       credits;
	int       grantMode;			// 0 low, 1 high, 2 random
	logic [15:0] lfsrState;

	byte      opList [$];
	int       argAList [$];
	int       argBList [$];
	int       stimLines;
	logic     stimLoaded;

	commitUnit uut (.*);

	initial begin
		clock = 1'b0;
		forever #(clockPeriod / 2) clock = ~clock;
	end

	////////////////////////////////////////
	// Failure and compare tasks
	////////////////////////////////////////

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped at first error");
	endtask

	task automatic checkIssueNo(input string name, input issueNoT actual, input issueNoT expected);
		if (actual !== expected)
			failRun($sformatf("FAIL at %0t: %s is %h, expected %h", $time, name, actual, expected));
	endtask

	task automatic checkCount(input string name, input countT actual, input countT expected);
		if (actual !== expected)
			failRun($sformatf("FAIL at %0t: %s is %0d, expected %0d", $time, name, actual, expected));
	endtask

	task automatic checkMask(input string name, input laneMaskT actual, input laneMaskT expected);
		if (actual !== expected)
			failRun($sformatf("FAIL at %0t: %s is %b, expected %b", $time, name, actual, expected));
	endtask

	task automatic checkEntry(input string name, input entryIdxT actual, input entryIdxT expected);
		if (actual !== expected)
			failRun($sformatf("FAIL at %0t: %s is %0d, expected %0d", $time, name, actual, expected));
	endtask

	////////////////////////////////////////
	// Random bits
	////////////////////////////////////////

	// Taps 16 14 13 11
	function automatic logic [15:0] lfsrNext(input logic [15:0] state);
		logic feedback;
		feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
		return {state[14:0], feedback};
	endfunction

	task automatic takeBits(input int count, output int value);
		value = 0;
		for (int i = 0; i < count; i++) begin
			lfsrState = lfsrNext(lfsrState);
			value = (value << 1) | int'(lfsrState[0]);
		end
	endtask

	function automatic logic anyPending();
		logic result;
		result = 1'b0;
		for (int i = 0; i < numEntries; i++)
			result = result | (pendingModel[i] != '0);
		return result;
	endfunction

	////////////////////////////////////////
	// Drive tasks
	////////////////////////////////////////

	// Moves past the next edge and clears single-cycle pulses
	task automatic stepCycle();
		int grantBit;
		@(posedge clock);
		#1;
		storeValid = 1'b0;
		laneDone   = '0;
		cfgWrite   = 1'b0;
		case (grantMode)
			0: commitGrant = 1'b0;
			1: commitGrant = 1'b1;
			default: begin
				takeBits(1, grantBit);
				commitGrant = grantBit[0];
			end
		endcase
	endtask

	task automatic storeEntry(input issueNoT issueNo, input laneMaskT lanes);
		stepCycle();
		while (credits == 0)
			stepCycle();		// Stalled until a credit comes back
		storeValid   = 1'b1;
		storeIssueNo = issueNo;
		storeLanes   = lanes;
		checkEntry("allocEntry", allocEntry, tailModel);
		pendingModel[tailModel] = lanes & enableModel;
		tailModel = tailModel + 1'b1;
		credits--;
		expectQ.push_back(issueNo);
	endtask

	// Random lanes report random entries until no work is left
	task automatic finishLanes();
		int fire;
		int offset;
		entryIdxT idx;
		logic found;
		while (anyPending()) begin
			stepCycle();
			for (int l = 0; l < numLanes; l++) begin
				takeBits(1, fire);
				if (fire != 0) begin
					takeBits(entryWidth, offset);
					found = 1'b0;
					for (int k = 0; k < numEntries; k++) begin
						idx = entryIdxT'(offset + k);
						if (!found && pendingModel[idx][l]) begin
							found = 1'b1;
							laneDone[l]  = 1'b1;
							laneEntry[l] = idx;
							pendingModel[idx][l] = 1'b0;
						end
					end
				end
			end
		end
	endtask

	task automatic drainCommits();
		while (expectQ.size() != 0)
			stepCycle();
		stepCycle();			// Commit edge
		stepCycle();			// Credit pulse seen
	endtask

	task automatic writeConfig(input int sel, input int data);
		stepCycle();
		cfgWrite     = 1'b1;
		cfgSelect    = cfgRegT'(sel);
		cfgWriteData = laneMaskT'(data);
		stepCycle();
		if (sel == 0)
			enableModel = laneMaskT'(data);
		else if (sel == 1)
			holdModel = data[0];
	endtask

	task automatic readConfig(input int sel, input int expected);
		stepCycle();
		cfgSelect = cfgRegT'(sel);
		@(negedge clock);
		if (sel == 2)
			checkCount("cfgReadData occupancy", countT'(cfgReadData[entryWidth:0]),
				countT'(expected));
		else
			checkMask("cfgReadData", cfgReadData, laneMaskT'(expected));
	endtask

	task automatic runCommand(input byte op, input int a, input int b);
		int lanes;
		case (op)
			"S": storeEntry(issueNoT'(a), laneMaskT'(b));
			"F": begin
				for (int i = 0; i < b; i++) begin
					takeBits(numLanes, lanes);
					storeEntry(issueNoT'(a + i), laneMaskT'(lanes));
				end
			end
			"L": finishLanes();
			"D": drainCommits();
			"G": grantMode = a;
			"I": repeat (a) stepCycle();
			"W": writeConfig(a, b);
			"R": readConfig(a, b);
			"K": checkCount("credit counter", countT'(credits), countT'(a));
			default: failRun($sformatf("Unknown stimulus command %c", op));
		endcase
	endtask

	////////////////////////////////////////
	// Commit monitor sampled mid-cycle
	////////////////////////////////////////

	always @(negedge clock) begin
		if (!reset) begin
			if (creditReturn) begin
				credits++;
				if (credits > numEntries)
					failRun("More credits returned than entries were stored");
			end
			if (commitValid) begin
				if (holdModel)
					failRun("Commit offered while commit hold was set");
				else if (expectQ.size() == 0)
					failRun("Commit offered with no entry outstanding");
				else if (pendingModel[headModel] != '0)
					failRun("Commit offered before all lanes of the head entry finished");
				else begin
					checkIssueNo("commitIssueNo", commitIssueNo, expectQ[0]);
					if (commitGrant) begin
						void'(expectQ.pop_front());
						headModel = headModel + 1'b1;
					end
				end
			end
		end
	end

	initial begin
		wait (stimLoaded);
		#(stimLines * cyclesPerLine * clockPeriod);
		failRun("Watchdog expired before the stimulus finished");
	end

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		int fd;
		string line;
		byte op;
		int a;
		int b;
		int fields;
		reset        = 1'b1;
		storeValid   = 1'b0;
		storeIssueNo = '0;
		storeLanes   = '0;
		laneDone     = '0;
		laneEntry    = '0;
		commitGrant  = 1'b0;
		cfgWrite     = 1'b0;
		cfgSelect    = regLaneEnable;
		cfgWriteData = '0;
		tailModel    = '0;
		headModel    = '0;
		enableModel  = '1;
		holdModel    = 1'b0;
		credits      = numEntries;
		grantMode    = 0;
		lfsrState    = 16'd23732;
		stimLoaded   = 1'b0;
		for (int i = 0; i < numEntries; i++)
			pendingModel[i] = '0;

		fd = $fopen("testbench/commitStim.txt", "r");
		if (fd == 0)
			failRun("Could not open the stimulus file testbench/commitStim.txt");
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			fields = $sscanf(line, "%c %h %h", op, a, b);
			if (fields != 3)
				failRun({"Malformed stimulus line: ", line});
			opList.push_back(op);
			argAList.push_back(a);
			argBList.push_back(b);
		end
		$fclose(fd);
		stimLines  = opList.size();
		stimLoaded = 1'b1;

		repeat (16) @(posedge clock);
		#1;
		reset = 1'b0;

		foreach (opList[i])
			runCommand(opList[i], argAList[i], argBList[i]);

		if (expectQ.size() != 0 || credits != numEntries)
			failRun("Run ended with commits outstanding or credits missing");
		else begin
			$display("NO ERRORS");
			$finish;
		end
	end

endmodule

// File: testbench/commitUnit_chk.sv
`timescale 1ns/1ps

module commitUnitChk
	import issuePkg::*;
(
	input logic    clock,
	input logic    reset,
	input logic    storeValid,
	input logic    full,
	input logic    commitValid,
	input issueNoT commitIssueNo,
	input logic    commitGrant,
	input logic    commitHold,
	input logic    creditReturn
);

	////////////////////////////////////////
	// Dispatch side
	////////////////////////////////////////

	// Dispatcher has no credit left once the buffer is full
	noStoreWhenFull: assert property (@(posedge clock) disable iff (reset)
		!(storeValid && full))
		else $error("Store attempted while the reorder buffer was full");

	////////////////////////////////////////
	// Commit side
	////////////////////////////////////////

	offerHeldUntilGrant: assert property (@(posedge clock) disable iff (reset || commitHold)
		commitValid && !commitGrant |=> commitValid && $stable(commitIssueNo))
		else $error("Commit offer dropped or changed before it was granted");

	creditAfterCommit: assert property (@(posedge clock) disable iff (reset)
		commitValid && commitGrant |=> creditReturn)
		else $error("No credit returned in the cycle after a commit");

	creditOnlyAfterCommit: assert property (@(posedge clock) disable iff (reset)
		creditReturn |-> $past(commitValid && commitGrant))
		else $error("Credit returned without a commit in the cycle before");

endmodule

bind reorderBuffer commitUnitChk chk (
	.clock         (clock),
	.reset         (reset),
	.storeValid    (storeValid),
	.full          (full),
	.commitValid   (commitValid),
	.commitIssueNo (commitIssueNo),
	.commitGrant   (commitGrant),
	.commitHold    (commitHold),
	.creditReturn  (creditReturn)
);

// File: verilog.f
source/issuePkg.sv
source/commitPkg.sv
source/ringBufferControl.sv
source/reorderBuffer.sv
source/commitConfig.sv
source/commitUnit.sv
testbench/commitUnit_chk.sv
testbench/commitUnitTb.sv
